// ==== Makefile ====
.PHONY: sim clean

# Build and run; status follows the search for the pass line
sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module rayGenTb -o simRayGen
	./obj_dir/simRayGen | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== hw/rayDirUnit.sv ====
`timescale 1ns/1ns

module rayDirUnit #(
    parameter int FrameHeight = 240,
    parameter int CoordWidth = 10
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  logic                                     issueValid,
    input  logic [CoordWidth-1:0]                    issueX,
    input  logic [CoordWidth-1:0]                    issueY,
    // Vectors indexed 0 = x, 1 = y, 2 = z
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camPos,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camBlc,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camRh,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camRv,
    input  logic [rayTracePkg::FixedWidth-1:0]      camCub,
    input  logic [rayTracePkg::FixedWidth-1:0]      camCvb,
    output logic [2:0][rayTracePkg::FixedWidth-1:0] dirOut
);

    import rayTracePkg::*;

    // Row flip origin, viewport height equals frame height
    localparam logic [CoordWidth-1:0] TopRow = CoordWidth'(FrameHeight - 1);

    // Q16.16 multiply
    // Full signed product, arithmetic shift, low word kept
    function automatic fixedWord_t mulFix(input fixedWord_t a, input fixedWord_t b);
        logic signed [2*FixedWidth-1:0] product;
        fixedWord_t result;
        product = a.raw * b.raw;
        result.raw = FixedWidth'(product >>> FracBits);
        return result;
    endfunction

    // Integer pixel coordinate into the whole part, zero fraction
    function automatic fixedWord_t toFixed(input logic [CoordWidth-1:0] coord);
        fixedWord_t word;
        word.parts.intPart = IntBits'(coord);
        word.parts.fracPart = '0;
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stage one
    ////////////////////////////////////////////////////////////////////////////

    logic [CoordWidth-1:0] flipRow;
    fixedWord_t            colWord;
    fixedWord_t            rowWord;
    // Scaled screen coordinates
    fixedWord_t            scaledU;
    fixedWord_t            scaledV;
    logic                  s1Valid;

    // Screen v grows upward, raster y grows downward
    assign flipRow = TopRow - issueY;
    assign colWord = toFixed(issueX);
    assign rowWord = toFixed(flipRow);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issueValid;
        end
    end

    // Holds between issues
    always_ff @(posedge clk) begin
        if (issueValid) begin
            scaledU <= mulFix(colWord, camCub);
            scaledV <= mulFix(rowWord, camCvb);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage two
    ////////////////////////////////////////////////////////////////////////////

    fixedWord_t [2:0] horiz;
    fixedWord_t [2:0] vert;
    fixedWord_t [2:0] dirNext;

    // dir = u*rh + v*rv + blc - pos, per axis, wrapping adds
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            horiz[k] = mulFix(scaledU, camRh[k]);
            vert[k] = mulFix(scaledV, camRv[k]);
            dirNext[k].raw = horiz[k].raw + vert[k].raw + camBlc[k] - camPos[k];
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid) begin
            dirOut <= dirNext;
        end
    end

endmodule

// ==== hw/rayGenTop.sv ====
`timescale 1ns/1ns

module rayGenTop #(
    parameter int FrameWidth = 320,
    parameter int FrameHeight = 240,
    parameter int NumCores = 4,
    parameter int CoordWidth = 10
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  logic                                     restart,
    input  logic                                     start,
    input  logic [CoordWidth-1:0]                    x0,
    input  logic [CoordWidth-1:0]                    y0,
    input  logic [NumCores-1:0]                      coreFull,
    // Camera vectors, index 0 = x, 1 = y, 2 = z
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camPos,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camBlc,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camRh,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] camRv,
    input  logic [rayTracePkg::FixedWidth-1:0]      camCub,
    input  logic [rayTracePkg::FixedWidth-1:0]      camCvb,
    output logic [NumCores-1:0]                      threadValid,
    output logic [CoordWidth-1:0]                    threadX,
    output logic [CoordWidth-1:0]                    threadY,
    output logic [2:0][rayTracePkg::FixedWidth-1:0] threadDir,
    output logic                                     frameDone
);

    import rayTracePkg::*;

    // Scheduler to datapath
    logic                        issueValid;
    logic [CoordWidth-1:0]       issueX;
    logic [CoordWidth-1:0]       issueY;
    logic [$clog2(NumCores)-1:0] issueCore;
    // Direction unit to dispatch
    fixedWord_t [2:0]            dirOut;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    threadScheduler #(
        .FrameWidth (FrameWidth),
        .FrameHeight(FrameHeight),
        .NumCores   (NumCores),
        .CoordWidth (CoordWidth)
    ) scheduler (
        .clk       (clk),
        .resetn    (resetn),
        .restart   (restart),
        .start     (start),
        .x0        (x0),
        .y0        (y0),
        .coreFull  (coreFull),
        .issueValid(issueValid),
        .issueX    (issueX),
        .issueY    (issueY),
        .issueCore (issueCore),
        .frameDone (frameDone)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    // Two cycles from issue to direction
    rayDirUnit #(
        .FrameHeight(FrameHeight),
        .CoordWidth (CoordWidth)
    ) dirUnit (
        .clk       (clk),
        .resetn    (resetn),
        .issueValid(issueValid),
        .issueX    (issueX),
        .issueY    (issueY),
        .camPos    (camPos),
        .camBlc    (camBlc),
        .camRh     (camRh),
        .camRv     (camRv),
        .camCub    (camCub),
        .camCvb    (camCvb),
        .dirOut    (dirOut)
    );

    // One more register to the cores
    threadDispatch #(
        .NumCores  (NumCores),
        .CoordWidth(CoordWidth)
    ) dispatch (
        .clk        (clk),
        .resetn     (resetn),
        .issueValid (issueValid),
        .issueX     (issueX),
        .issueY     (issueY),
        .issueCore  (issueCore),
        .dirOut     (dirOut),
        .threadValid(threadValid),
        .threadX    (threadX),
        .threadY    (threadY),
        .threadDir  (threadDir)
    );

endmodule

// ==== hw/rayTracePkg.sv ====
package rayTracePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed-point format
    ////////////////////////////////////////////////////////////////////////////

    // Q16.16 word, signed two's complement
    localparam int FixedWidth = 32;

    // Bits right of the binary point
    localparam int FracBits = 16;

    // Bits left of the binary point, sign included
    localparam int IntBits = FixedWidth - FracBits;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed-point word
    ////////////////////////////////////////////////////////////////////////////

    // Two views of the same 32 bits
    // Raw view feeds the multipliers and adders
    // Split view builds a word from an integer pixel coordinate
    typedef union packed {
        logic signed [FixedWidth-1:0] raw;
        struct packed {
            // Whole part, upper half
            logic signed [IntBits-1:0] intPart;
            // Fraction, lower half
            logic [FracBits-1:0] fracPart;
        } parts;
    } fixedWord_t;

endpackage

// ==== hw/threadDispatch.sv ====
`timescale 1ns/1ns

module threadDispatch #(
    parameter int NumCores = 4,
    parameter int CoordWidth = 10
) (
    input  logic                                     clk,
    input  logic                                     resetn,
    input  logic                                     issueValid,
    input  logic [CoordWidth-1:0]                    issueX,
    input  logic [CoordWidth-1:0]                    issueY,
    input  logic [$clog2(NumCores)-1:0]              issueCore,
    input  logic [2:0][rayTracePkg::FixedWidth-1:0] dirOut,
    output logic [NumCores-1:0]                      threadValid,
    output logic [CoordWidth-1:0]                    threadX,
    output logic [CoordWidth-1:0]                    threadY,
    output logic [2:0][rayTracePkg::FixedWidth-1:0] threadDir
);

    localparam int CoreWidth = $clog2(NumCores);

    ////////////////////////////////////////////////////////////////////////////
    // Sideband delay, matches the two direction stages
    ////////////////////////////////////////////////////////////////////////////

    // Index 0 is the first stage, index 1 lines up with dirOut
    logic [1:0]                 validPipe;
    logic [1:0][CoordWidth-1:0] xPipe;
    logic [1:0][CoordWidth-1:0] yPipe;
    logic [1:0][CoreWidth-1:0]  corePipe;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            validPipe   <= '0;
            threadValid <= '0;
        end else begin
            validPipe <= {validPipe[0], issueValid};
            // One-hot select of the target core
            if (validPipe[1]) begin
                threadValid <= NumCores'(1) << corePipe[1];
            end else begin
                threadValid <= '0;
            end
        end
    end

    // Sideband moves with its valid bit
    always_ff @(posedge clk) begin
        if (issueValid) begin
            xPipe[0]    <= issueX;
            yPipe[0]    <= issueY;
            corePipe[0] <= issueCore;
        end
        if (validPipe[0]) begin
            xPipe[1]    <= xPipe[0];
            yPipe[1]    <= yPipe[0];
            corePipe[1] <= corePipe[0];
        end
        // Output record register
        if (validPipe[1]) begin
            threadX   <= xPipe[1];
            threadY   <= yPipe[1];
            threadDir <= dirOut;
        end
    end

endmodule

// ==== hw/threadScheduler.sv ====
`timescale 1ns/1ns

module threadScheduler #(
    parameter int FrameWidth = 320,
    parameter int FrameHeight = 240,
    parameter int NumCores = 4,
    parameter int CoordWidth = 10
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        restart,
    input  logic                        start,
    input  logic [CoordWidth-1:0]       x0,
    input  logic [CoordWidth-1:0]       y0,
    input  logic [NumCores-1:0]         coreFull,
    output logic                        issueValid,
    output logic [CoordWidth-1:0]       issueX,
    output logic [CoordWidth-1:0]       issueY,
    output logic [$clog2(NumCores)-1:0] issueCore,
    output logic                        frameDone
);

    localparam int CoreWidth = $clog2(NumCores);

    // FSM encoding
    localparam logic [1:0] StateInit     = 2'd0;
    localparam logic [1:0] StateWait     = 2'd1;
    localparam logic [1:0] StateGenerate = 2'd2;
    localparam logic [1:0] StateNext     = 2'd3;

    // Last column, row and core of a walk
    localparam logic [CoordWidth-1:0] LastCol  = CoordWidth'(FrameWidth - 1);
    localparam logic [CoordWidth-1:0] LastRow  = CoordWidth'(FrameHeight - 1);
    localparam logic [CoreWidth-1:0]  LastCore = CoreWidth'(NumCores - 1);

    logic [1:0]            state;
    // Pixel cursor
    logic [CoordWidth-1:0] curX;
    logic [CoordWidth-1:0] curY;
    // Round-robin pointer
    logic [CoreWidth-1:0]  curCore;

    ////////////////////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////////////////////

    // Only back-pressure point in the generator
    // Selected core full means hold the cursor and wait
    assign issueValid = (state == StateGenerate) && !coreFull[curCore];

    // Cursor goes straight to the datapath
    assign issueX    = curX;
    assign issueY    = curY;
    assign issueCore = curCore;

    ////////////////////////////////////////////////////////////////////////////
    // Walk control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= StateInit;
            curX      <= '0;
            curY      <= '0;
            curCore   <= '0;
            frameDone <= 1'b0;
        end else begin
            // Single-cycle strobe
            frameDone <= 1'b0;
            case (state)
                StateInit: begin
                    // Restart only counts here
                    if (restart) begin
                        curX    <= x0;
                        curY    <= y0;
                        curCore <= '0;
                        state   <= StateWait;
                    end
                end
                StateWait: begin
                    if (start) begin
                        state <= StateGenerate;
                    end
                end
                StateGenerate: begin
                    // Stay on this core until it takes the thread
                    if (issueValid) begin
                        state <= StateNext;
                    end
                end
                StateNext: begin
                    // Core index wraps modulo NumCores
                    if (curCore >= LastCore) begin
                        curCore <= '0;
                    end else begin
                        curCore <= curCore + 1'b1;
                    end
                    if (curX >= LastCol) begin
                        // New row restarts at x0
                        curX <= x0;
                        if (curY >= LastRow) begin
                            // Frame finished, back to idle
                            frameDone <= 1'b1;
                            state     <= StateInit;
                        end else begin
                            curY  <= curY + 1'b1;
                            state <= StateGenerate;
                        end
                    end else begin
                        curX  <= curX + 1'b1;
                        state <= StateGenerate;
                    end
                end
                default: begin
                    state <= StateInit;
                end
            endcase
        end
    end

endmodule

// ==== sources.f ====
hw/rayTracePkg.sv
hw/threadScheduler.sv
hw/rayDirUnit.sv
hw/threadDispatch.sv
hw/rayGenTop.sv
verification/clockGen.sv
verification/rayGenTb.sv

// ==== verification/clockGen.sv ====
`timescale 1ns/1ns

module clockGen #(
    parameter int HalfPeriod = 20,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic resetn
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Reset low for the first few rising edges
    initial begin
        resetn = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// ==== verification/rayGenTb.sv ====
`timescale 1ns/1ns

module rayGenTb;

    import rayTracePkg::*;

    localparam int Width = 8;
    localparam int Height = 4;
    localparam int Cores = 3;
    localparam int CoordW = 8;
    // Cycle limit of any single wait
    localparam int Timeout = 2000;

    logic                       clk;
    logic                       resetn;
    logic                       restart;
    logic                       start;
    logic [CoordW-1:0]          x0;
    logic [CoordW-1:0]          y0;
    logic [Cores-1:0]           coreFull;
    logic [2:0][FixedWidth-1:0] camPos;
    logic [2:0][FixedWidth-1:0] camBlc;
    logic [2:0][FixedWidth-1:0] camRh;
    logic [2:0][FixedWidth-1:0] camRv;
    logic [FixedWidth-1:0]      camCub;
    logic [FixedWidth-1:0]      camCvb;
    logic [Cores-1:0]           threadValid;
    logic [CoordW-1:0]          threadX;
    logic [CoordW-1:0]          threadY;
    logic [2:0][FixedWidth-1:0] threadDir;
    logic                       frameDone;

    // Random coreFull pattern on/off
    logic        fullMode;
    logic [31:0] lfsrState;
    int          errors;
    int          received;
    int          doneCount;
    // Edges in a row each core was seen full
    int          highRun [Cores];
    // Expected threads in raster order
    int          expX[$];
    int          expY[$];
    int          expCore[$];

    clockGen clocks (
        .clk   (clk),
        .resetn(resetn)
    );

    rayGenTop #(
        .FrameWidth (Width),
        .FrameHeight(Height),
        .NumCores   (Cores),
        .CoordWidth (CoordW)
    ) dut (
        .clk        (clk),
        .resetn     (resetn),
        .restart    (restart),
        .start      (start),
        .x0         (x0),
        .y0         (y0),
        .coreFull   (coreFull),
        .camPos     (camPos),
        .camBlc     (camBlc),
        .camRh      (camRh),
        .camRv      (camRv),
        .camCub     (camCub),
        .camCvb     (camCvb),
        .threadValid(threadValid),
        .threadX    (threadX),
        .threadY    (threadY),
        .threadDir  (threadDir),
        .frameDone  (frameDone)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped one shift per bit
    function automatic logic nextBit();
        logic out;
        out = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (out) begin
            lfsrState = lfsrState ^ 32'hD0000001;
        end
        return out;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], nextBit()};
        end
        return value;
    endfunction

    // Signed value within about +-2.0
    function automatic logic [FixedWidth-1:0] randSmall();
        logic [17:0] bits;
        bits = 18'(randBits(18));
        return {{14{bits[17]}}, bits};
    endfunction

    // Q16.16 product shifted back and truncated
    function automatic logic [FixedWidth-1:0] mulRef(input logic [FixedWidth-1:0] a,
                                                     input logic [FixedWidth-1:0] b);
        longint product;
        product = longint'($signed(a)) * longint'($signed(b));
        return FixedWidth'(product >>> FracBits);
    endfunction

    // Camera ray direction of one pixel on one axis
    function automatic logic [FixedWidth-1:0] expectDir(input int x, input int y, input int axis);
        logic [FixedWidth-1:0] u;
        logic [FixedWidth-1:0] v;
        u = mulRef(FixedWidth'(x) << FracBits, camCub);
        // Rows count upward on screen
        v = mulRef(FixedWidth'(Height - 1 - y) << FracBits, camCvb);
        return mulRef(u, camRh[axis]) + mulRef(v, camRv[axis]) + camBlc[axis] - camPos[axis];
    endfunction

    task automatic reportError(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: gave up after %0d cycles waiting for %s", Timeout, what);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // New pattern each cycle when enabled
    always @(posedge clk) begin
        if (fullMode) begin
            coreFull <= Cores'(randBits(Cores));
        end else begin
            coreFull <= '0;
        end
    end

    // Strobe start alone and expect the FSM to stay idle
    task automatic startWithoutRestart(input string name);
        int errorsBefore;
        int receivedBefore;
        int doneBefore;
        errorsBefore = errors;
        receivedBefore = received;
        doneBefore = doneCount;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (40) @(posedge clk);
        assert (received == receivedBefore)
            else reportError("thread issued after start without restart");
        assert (doneCount == doneBefore)
            else reportError("frameDone pulsed after start without restart");
        $display("%s: %s", name, (errors == errorsBefore) ? "passed" : "failed");
    endtask

    // One frame at random x0, y0 and camera
    task automatic runFrame(input logic randomFull, input string name);
        int errorsBefore;
        int doneBefore;
        int startX;
        int startY;
        int index;
        int cycles;
        errorsBefore = errors;
        doneBefore = doneCount;
        startX = int'(randBits(2));
        startY = int'(randBits(1));
        index = 0;
        for (int y = startY; y < Height; y++) begin
            for (int x = startX; x < Width; x++) begin
                expX.push_back(x);
                expY.push_back(y);
                // Cores take turns
                expCore.push_back(index % Cores);
                index++;
            end
        end
        @(posedge clk);
        for (int k = 0; k < 3; k++) begin
            camPos[k] <= randSmall();
            camBlc[k] <= randSmall();
            camRh[k] <= randSmall();
            camRv[k] <= randSmall();
        end
        camCub <= randSmall();
        camCvb <= randSmall();
        x0 <= CoordW'(startX);
        y0 <= CoordW'(startY);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        start <= 1'b1;
        fullMode <= randomFull;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (expX.size() > 0 && cycles < Timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (expX.size() > 0) begin
            reportTimeout($sformatf("%0d remaining threads", expX.size()));
            expX.delete();
            expY.delete();
            expCore.delete();
        end
        fullMode <= 1'b0;
        // Extra threads or pulses show up in the drain
        repeat (10) @(posedge clk);
        assert (doneCount == doneBefore + 1)
            else reportError($sformatf("%0d frameDone pulses", doneCount - doneBefore));
        $display("%s: %s, %0d threads", name, (errors == errorsBefore) ? "passed" : "failed",
                 index);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int core;
        int ex;
        int ey;
        int ec;
        for (int c = 0; c < Cores; c++) begin
            highRun[c] = coreFull[c] ? highRun[c] + 1 : 0;
        end
        if (frameDone) begin
            doneCount++;
        end
        if (!resetn) begin
            assert (threadValid == '0 && frameDone == 1'b0)
                else reportError("threadValid or frameDone high in reset");
        end else if (threadValid != '0) begin
            received++;
            core = 0;
            for (int c = 0; c < Cores; c++) begin
                if (threadValid[c]) begin
                    core = c;
                end
            end
            assert ($onehot(threadValid))
                else reportError($sformatf("threadValid %b not one-hot", threadValid));
            // Issue was 3 edges back so full was low then
            assert (highRun[core] < 4)
                else reportError($sformatf("core %0d got a thread while held full", core));
            assert (expX.size() > 0)
                else reportError("thread arrived with none expected");
            if (expX.size() > 0) begin
                ex = expX.pop_front();
                ey = expY.pop_front();
                ec = expCore.pop_front();
                assert (threadX == CoordW'(ex) && threadY == CoordW'(ey))
                    else reportError($sformatf("pixel (%0d,%0d), expected (%0d,%0d)",
                                               threadX, threadY, ex, ey));
                assert (core == ec)
                    else reportError($sformatf("core %0d, expected %0d", core, ec));
                for (int k = 0; k < 3; k++) begin
                    assert (threadDir[k] == expectDir(ex, ey, k))
                        else reportError($sformatf("dir[%0d] %h, expected %h", k, threadDir[k],
                                                   expectDir(ex, ey, k)));
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        lfsrState = 32'he4092011;
        errors = 0;
        received = 0;
        doneCount = 0;
        foreach (highRun[c]) begin
            highRun[c] = 0;
        end
        restart = 1'b0;
        start = 1'b0;
        x0 = '0;
        y0 = '0;
        coreFull = '0;
        camPos = '0;
        camBlc = '0;
        camRh = '0;
        camRv = '0;
        camCub = '0;
        camCvb = '0;
        fullMode = 1'b0;
        cycles = 0;
        while (resetn !== 1'b1 && cycles < Timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (resetn !== 1'b1) begin
            reportTimeout("reset release");
        end
        startWithoutRestart("reset state");
        runFrame(1'b0, "scan order and directions");
        runFrame(1'b1, "back-pressure");
        startWithoutRestart("start without restart after frame");
        runFrame(1'b1, "second frame after restart");
        $display("Threads received: %0d, frames done: %0d, errors: %0d",
                 received, doneCount, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
